// ==== rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    localparam int pr_addr_w  = 5;
    localparam int arch_w     = 4;
    localparam int num_ren    = 10;   // arch regs 2..11
    localparam int num_pr     = 32;
    localparam int first_free = 12;   // first tag handed to the free list

    localparam logic [3:0] op_bit   = 4'd11;
    localparam logic [3:0] op_load  = 4'd12;
    localparam logic [3:0] op_store = 4'd13;
    localparam logic [3:0] op_cterm = 4'd14;
    localparam logic [3:0] op_term  = 4'd15;

    // two dests, three sources
    typedef struct packed {
        logic [3:0]        opcode;
        logic [arch_w-1:0] dst1;
        logic [arch_w-1:0] dst0;
        logic [arch_w-1:0] src2;
        logic [arch_w-1:0] src1;
        logic [arch_w-1:0] src0;
    } uop_alu_t;

    // memory and control ops, field meaning depends on opcode
    typedef struct packed {
        logic [3:0]        opcode;
        logic [3:0]        imm;
        logic [arch_w-1:0] f3;
        logic [arch_w-1:0] f2;
        logic [arch_w-1:0] f1;
        logic [arch_w-1:0] f0;
    } uop_mem_t;

    typedef union packed {
        uop_alu_t alu;
        uop_mem_t mem;
    } microop_t;

endpackage

`default_nettype wire

// ==== dest_if.sv ====
`default_nettype none

interface dest_if import rename_pkg::*; ();

    logic                 wr_en0;
    logic                 wr_en1;
    logic [arch_w-1:0]    wr_arch0;
    logic [arch_w-1:0]    wr_arch1;
    logic [pr_addr_w-1:0] wr_tag0;
    logic [pr_addr_w-1:0] wr_tag1;

    modport ctrl (
        output wr_en0, wr_en1, wr_arch0, wr_arch1, wr_tag0, wr_tag1
    );

    // alias table side
    modport rat (
        input wr_en0, wr_en1, wr_arch0, wr_arch1, wr_tag0, wr_tag1
    );

    modport board (
        input wr_en0, wr_en1, wr_tag0, wr_tag1
    );

endinterface

`default_nettype wire

// ==== rename_lookup.sv ====
`default_nettype none

module rename_lookup import rename_pkg::*; #(
    parameter int num_ren = rename_pkg::num_ren
) (
    input  wire logic [arch_w-1:0]                   arch_reg,
    input  wire logic [num_ren-1:0]                  rat_done,
    input  wire logic [num_pr-1:0]                   phys_reg_done,
    input  wire logic [num_ren-1:0][pr_addr_w-1:0]   rat_aliases,
    output logic      [pr_addr_w-1:0]                phys_reg,
    output logic                                     ready
);

    logic              is_const;
    logic              in_range;
    logic [arch_w-1:0] idx;

    assign is_const = arch_reg < arch_w'(2);
    assign in_range = arch_reg < arch_w'(num_ren + 2);
    assign idx      = arch_reg - arch_w'(2);

    // regs past the renamable range read as tag 0
    assign phys_reg = is_const ? pr_addr_w'(arch_reg)
                    : in_range ? rat_aliases[idx]
                    : '0;
    assign ready    = is_const | ~in_range | rat_done[idx] | phys_reg_done[phys_reg];

endmodule

`default_nettype wire

// ==== rename_decoder.sv ====
`default_nettype none

module rename_decoder import rename_pkg::*; #(
    parameter int num_ren = rename_pkg::num_ren
) (
    input  wire microop_t                            microop,
    input  wire logic [num_ren-1:0]                  rat_done,
    input  wire logic [num_pr-1:0]                   phys_reg_done,
    input  wire logic [num_ren-1:0][pr_addr_w-1:0]   rat_aliases,
    output logic      [3:0][pr_addr_w-1:0]           src_regs,
    output logic      [3:0]                          src_ready,
    output logic      [3:0]                          immediate,
    output logic      [arch_w-1:0]                   dst_arch0,
    output logic      [arch_w-1:0]                   dst_arch1,
    output logic      [1:0]                          dst_need
);

    logic [3:0][arch_w-1:0] src_arch;   // slot 3 .. slot 0
    logic                   wr0;
    logic                   wr1;

    function automatic logic is_real(input logic [arch_w-1:0] r);
        return (r >= arch_w'(2)) && (r < arch_w'(num_ren + 2));
    endfunction

    always_comb begin
        wr0       = 1'b0;
        wr1       = 1'b0;
        immediate = microop.mem.imm;
        case (microop.mem.opcode)
            op_bit: begin
                immediate = microop.mem.f0;
                src_arch  = {4'h0, microop.mem.f2, microop.mem.f1, 4'h0};
                wr0       = 1'b1;
            end
            op_load: begin
                src_arch = {4'h0, microop.mem.f2, microop.mem.f1, microop.mem.f0};
                wr0      = 1'b1;
            end
            op_store: begin
                src_arch = {microop.mem.f3, microop.mem.f2, microop.mem.f1, microop.mem.f0};
            end
            op_cterm: begin
                // imm field reused as a source so regs keep their slots
                immediate = microop.mem.f0;
                src_arch  = {microop.mem.f3, microop.mem.f2, microop.mem.f1, microop.mem.imm};
            end
            op_term: begin
                immediate = microop.mem.f0;
                src_arch  = {microop.mem.f3, 8'h00, microop.mem.imm};
            end
            default: begin  // alu op
                immediate = 4'h0;
                src_arch  = {4'h0, microop.alu.src2, microop.alu.src1, microop.alu.src0};
                wr0       = 1'b1;
                wr1       = 1'b1;
            end
        endcase
    end

    assign dst_arch0   = microop.alu.dst0;
    assign dst_arch1   = microop.alu.dst1;
    assign dst_need[0] = wr0 & is_real(microop.alu.dst0);
    assign dst_need[1] = wr1 & is_real(microop.alu.dst1);

    for (genvar i = 0; i < 4; i++) begin : g_slot
        rename_lookup #(
            .num_ren(num_ren)
        ) u_lookup (
            .arch_reg     (src_arch[i]),
            .rat_done     (rat_done),
            .phys_reg_done(phys_reg_done),
            .rat_aliases  (rat_aliases),
            .phys_reg     (src_regs[i]),
            .ready        (src_ready[i])
        );
    end

endmodule

`default_nettype wire

// ==== alias_table.sv ====
`default_nettype none

module alias_table import rename_pkg::*; #(
    parameter int num_ren = rename_pkg::num_ren
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    dest_if.rat                                    dest,
    output logic [num_ren-1:0][pr_addr_w-1:0]      rat_aliases,
    output logic [num_ren-1:0]                     rat_done
);

    logic [num_ren-1:0][pr_addr_w-1:0] alias_q;
    logic [num_ren-1:0]                done_q;
    logic [arch_w-1:0]                 idx0;
    logic [arch_w-1:0]                 idx1;

    assign idx0 = dest.wr_arch0 - arch_w'(2);
    assign idx1 = dest.wr_arch1 - arch_w'(2);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_ren; i++) begin
                alias_q[i] <= pr_addr_w'(i + 2);   // identity map
            end
            done_q <= '1;
        end else begin
            if (dest.wr_en0) begin
                alias_q[idx0] <= dest.wr_tag0;
                done_q[idx0]  <= 1'b0;
            end
            if (dest.wr_en1) begin     // later write wins on same reg
                alias_q[idx1] <= dest.wr_tag1;
                done_q[idx1]  <= 1'b0;
            end
        end
    end

    assign rat_aliases = alias_q;
    assign rat_done    = done_q;

endmodule

`default_nettype wire

// ==== free_list.sv ====
`default_nettype none

module free_list import rename_pkg::*; #(
    parameter int  fifo_depth = 32,
    localparam int ptr_w      = $clog2(fifo_depth),
    localparam int cnt_w      = $clog2(fifo_depth + 1)
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 pop0,
    input  wire logic                 pop1,
    input  wire logic                 push,
    input  wire logic [pr_addr_w-1:0] push_tag,
    output logic      [pr_addr_w-1:0] head0,
    output logic      [pr_addr_w-1:0] head1,
    output logic      [cnt_w-1:0]     count
);

    logic [pr_addr_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]     rd_ptr;
    logic [ptr_w-1:0]     wr_ptr;
    logic [cnt_w-1:0]     cnt_q;
    logic [1:0]           n_pop;

    assign n_pop = {1'b0, pop0} + {1'b0, pop1};

    assign head0 = mem[rd_ptr];
    // lone pop1 takes the head entry
    assign head1 = pop0 ? mem[rd_ptr + ptr_w'(1)] : mem[rd_ptr];
    assign count = cnt_q;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            cnt_q  <= '0;      // empty until start-up fill
        end else begin
            rd_ptr <= rd_ptr + ptr_w'(n_pop);
            wr_ptr <= wr_ptr + ptr_w'(push);
            cnt_q  <= cnt_q + cnt_w'(push) - cnt_w'(n_pop);
        end
    end

endmodule

`default_nettype wire

// ==== ready_board.sv ====
`default_nettype none

module ready_board import rename_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 wb_valid,
    input  wire logic [pr_addr_w-1:0] wb_tag,
    dest_if.board                     dest,
    output logic      [num_pr-1:0]    phys_reg_done
);

    logic [num_pr-1:2] done_q;   // tags 0 and 1 are constants

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= '1;
        end else begin
            if (wb_valid && wb_tag >= pr_addr_w'(2)) begin
                done_q[wb_tag] <= 1'b1;
            end
            // a fresh allocation is not done yet
            if (dest.wr_en0) begin
                done_q[dest.wr_tag0] <= 1'b0;
            end
            if (dest.wr_en1) begin
                done_q[dest.wr_tag1] <= 1'b0;
            end
        end
    end

    assign phys_reg_done = {done_q, 2'b11};

endmodule

`default_nettype wire

// ==== init_counter.sv ====
`default_nettype none

module init_counter import rename_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 run,
    output logic      [pr_addr_w-1:0] tag,
    output logic                      last
);

    logic [pr_addr_w-1:0] tag_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_q <= pr_addr_w'(first_free);
        end else if (run && !last) begin
            tag_q <= tag_q + pr_addr_w'(1);
        end
    end

    assign tag  = tag_q;
    assign last = tag_q == pr_addr_w'(num_pr - 1);   // final tag of the fill

endmodule

`default_nettype wire

// ==== rename_ctrl.sv ====
`default_nettype none

module rename_ctrl import rename_pkg::*; #(
    parameter int count_w = 6
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 in_valid,
    input  wire logic [arch_w-1:0]    dst_arch0,
    input  wire logic [arch_w-1:0]    dst_arch1,
    input  wire logic [1:0]           dst_need,
    input  wire logic [count_w-1:0]   count,
    input  wire logic [pr_addr_w-1:0] head0,
    input  wire logic [pr_addr_w-1:0] head1,
    input  wire logic                 init_last,
    output logic                      in_ready,
    output logic                      accept,
    output logic                      init_run,
    output logic                      pop0,
    output logic                      pop1,
    dest_if.ctrl                      dest
);

    typedef enum logic {INIT, RUN} state_t;

    state_t     state;
    logic [1:0] need;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= INIT;
        end else if (state == INIT && init_last) begin
            state <= RUN;
        end
    end

    assign need     = {1'b0, dst_need[0]} + {1'b0, dst_need[1]};
    assign init_run = state == INIT;
    // stall when the free list cannot cover this microop
    assign in_ready = (state == RUN) && (count >= count_w'(need));
    assign accept   = in_valid & in_ready;
    assign pop0     = accept & dst_need[0];
    assign pop1     = accept & dst_need[1];

    assign dest.wr_en0   = pop0;
    assign dest.wr_en1   = pop1;
    assign dest.wr_arch0 = dst_arch0;
    assign dest.wr_arch1 = dst_arch1;
    assign dest.wr_tag0  = head0;
    assign dest.wr_tag1  = head1;

endmodule

`default_nettype wire

// ==== rename_unit.sv ====
`default_nettype none

module rename_unit import rename_pkg::*; #(
    parameter int num_ren    = rename_pkg::num_ren,
    parameter int fifo_depth = 32
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      in_valid,
    input  wire microop_t                  microop,
    output logic                           in_ready,
    input  wire logic                      wb_valid,
    input  wire logic [pr_addr_w-1:0]      wb_tag,
    input  wire logic                      free_valid,
    input  wire logic [pr_addr_w-1:0]      free_tag,
    output logic                           out_valid,
    output logic      [3:0][pr_addr_w-1:0] src_regs,
    output logic      [3:0]                src_ready,
    output logic      [3:0]                immediate,
    output logic      [1:0][pr_addr_w-1:0] dst_tags,
    output logic      [1:0]                dst_valid
);

    localparam int count_w = $clog2(fifo_depth + 1);

    logic [num_ren-1:0][pr_addr_w-1:0] rat_aliases;
    logic [num_ren-1:0]                rat_done;
    logic [num_pr-1:0]                 phys_reg_done;
    logic [3:0][pr_addr_w-1:0]         dec_src_regs;
    logic [3:0]                        dec_src_ready;
    logic [3:0]                        dec_imm;
    logic [arch_w-1:0]                 dst_arch0;
    logic [arch_w-1:0]                 dst_arch1;
    logic [1:0]                        dst_need;
    logic                              accept;
    logic                              init_run;
    logic                              init_last;
    logic [pr_addr_w-1:0]              init_tag;
    logic                              pop0;
    logic                              pop1;
    logic [pr_addr_w-1:0]              head0;
    logic [pr_addr_w-1:0]              head1;
    logic [count_w-1:0]                count;
    logic                              push;
    logic [pr_addr_w-1:0]              push_tag;

    dest_if dst ();

    rename_decoder #(
        .num_ren(num_ren)
    ) u_decoder (
        .microop      (microop),
        .rat_done     (rat_done),
        .phys_reg_done(phys_reg_done),
        .rat_aliases  (rat_aliases),
        .src_regs     (dec_src_regs),
        .src_ready    (dec_src_ready),
        .immediate    (dec_imm),
        .dst_arch0    (dst_arch0),
        .dst_arch1    (dst_arch1),
        .dst_need     (dst_need)
    );

    alias_table #(
        .num_ren(num_ren)
    ) u_rat (
        .clk        (clk),
        .rst        (rst),
        .dest       (dst.rat),
        .rat_aliases(rat_aliases),
        .rat_done   (rat_done)
    );

    // start-up fill first, recycled tags afterwards
    assign push     = init_run | free_valid;
    assign push_tag = init_run ? init_tag : free_tag;

    free_list #(
        .fifo_depth(fifo_depth)
    ) u_free_list (
        .clk     (clk),
        .rst     (rst),
        .pop0    (pop0),
        .pop1    (pop1),
        .push    (push),
        .push_tag(push_tag),
        .head0   (head0),
        .head1   (head1),
        .count   (count)
    );

    ready_board u_board (
        .clk          (clk),
        .rst          (rst),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .dest         (dst.board),
        .phys_reg_done(phys_reg_done)
    );

    init_counter u_init (
        .clk (clk),
        .rst (rst),
        .run (init_run),
        .tag (init_tag),
        .last(init_last)
    );

    rename_ctrl #(
        .count_w(count_w)
    ) u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .dst_arch0(dst_arch0),
        .dst_arch1(dst_arch1),
        .dst_need (dst_need),
        .count    (count),
        .head0    (head0),
        .head1    (head1),
        .init_last(init_last),
        .in_ready (in_ready),
        .accept   (accept),
        .init_run (init_run),
        .pop0     (pop0),
        .pop1     (pop1),
        .dest     (dst.ctrl)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            dst_valid <= '0;
        end else begin
            out_valid <= accept;
            dst_valid <= {dst.wr_en1, dst.wr_en0};
        end
    end

    // payload, qualified by out_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            src_regs  <= dec_src_regs;
            src_ready <= dec_src_ready;
            immediate <= dec_imm;
            dst_tags  <= {dst.wr_tag1, dst.wr_tag0};
        end
    end

endmodule

`default_nettype wire

// ==== rename_props.sv ====
`default_nettype none

module rename_props import rename_pkg::*; (
    input wire logic                      clk,
    input wire logic                      rst,
    input wire logic                      in_valid,
    input wire logic                      init_run,
    input wire logic                      in_ready,
    input wire logic                      out_valid,
    input wire logic [1:0]                dst_valid,
    input wire logic [1:0][pr_addr_w-1:0] dst_tags
);

    timeunit 1ns;
    timeprecision 100ps;

    int fails = 0;   // read back by the testbench

    a_out_after_accept: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid && in_ready))
        else begin
            $error("out_valid without an accepting cycle before it");
            fails++;
        end

    // start-up holds off the source for the whole 20-tag fill
    a_no_ready_in_init: assert property (@(posedge clk) disable iff (rst)
        $fell(rst) |-> (init_run && !in_ready) [*20] ##1 (!init_run && in_ready))
        else begin
            $error("in_ready not held low through the 20-cycle start-up");
            fails++;
        end

    // constant tags are never handed out
    a_dst0_not_const: assert property (@(posedge clk) disable iff (rst)
        dst_valid[0] |-> dst_tags[0] > pr_addr_w'(1))
        else begin
            $error("dst_tags[0] is a constant tag");
            fails++;
        end

    a_dst1_not_const: assert property (@(posedge clk) disable iff (rst)
        dst_valid[1] |-> dst_tags[1] > pr_addr_w'(1))
        else begin
            $error("dst_tags[1] is a constant tag");
            fails++;
        end

endmodule

bind rename_unit rename_props u_props (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .init_run (init_run),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .dst_valid(dst_valid),
    .dst_tags (dst_tags)
);

`default_nettype wire

// ==== tb_rename_unit.sv ====
`default_nettype none

module tb_rename_unit import rename_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_cycles = 3000;
    localparam int max_cycles = 16 + 40 + num_cycles + 50;   // reset, start-up, stimulus, margin

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    microop_t                  microop;
    logic                      in_ready;
    logic                      wb_valid;
    logic [pr_addr_w-1:0]      wb_tag;
    logic                      free_valid;
    logic [pr_addr_w-1:0]      free_tag;
    logic                      out_valid;
    logic [3:0][pr_addr_w-1:0] src_regs;
    logic [3:0]                src_ready;
    logic [3:0]                immediate;
    logic [1:0][pr_addr_w-1:0] dst_tags;
    logic [1:0]                dst_valid;

    // reference model
    logic [pr_addr_w-1:0] rat [16];
    logic                 rat_done [16];
    logic                 pdone [num_pr];
    logic [pr_addr_w-1:0] free_q [$];
    logic [pr_addr_w-1:0] inflight [$];   // allocated, not yet written back
    logic [pr_addr_w-1:0] retired [$];    // unmapped, waiting to be freed

    // expected outputs of the last accepted microop
    logic                      exp_valid;
    logic [3:0][pr_addr_w-1:0] exp_src;
    logic [3:0]                exp_rdy;
    logic [3:0]                exp_imm;
    logic [1:0][pr_addr_w-1:0] exp_tags;
    logic [1:0]                exp_dvalid;
    logic                      pend_acc;
    logic [1:0]                pend_need;
    logic [arch_w-1:0]         pend_d0;
    logic [arch_w-1:0]         pend_d1;

    string  test_name [5] = '{"startup", "translate", "readiness", "allocation", "backpressure"};
    int     errs [5];
    int     checks [5];
    int     allocs;
    integer seed = 32'h7f70_e4a3;

    rename_unit #(
        .num_ren   (num_ren),
        .fifo_depth(32)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .microop   (microop),
        .in_ready  (in_ready),
        .wb_valid  (wb_valid),
        .wb_tag    (wb_tag),
        .free_valid(free_valid),
        .free_tag  (free_tag),
        .out_valid (out_valid),
        .src_regs  (src_regs),
        .src_ready (src_ready),
        .immediate (immediate),
        .dst_tags  (dst_tags),
        .dst_valid (dst_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (max_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_value(input int t, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks[t]++;
        assert (act === exp) else begin
            $display("Mismatch %s %s: expected %0h, actual %0h", test_name[t], what, exp, act);
            errs[t]++;
        end
    endtask

    function automatic logic is_real(input logic [arch_w-1:0] r);
        return r >= 4'd2 && r <= 4'd11;
    endfunction

    function automatic logic [pr_addr_w-1:0] model_tag(input logic [arch_w-1:0] r);
        if (r < 4'd2) return pr_addr_w'(r);
        if (r > 4'd11) return '0;
        return rat[r];
    endfunction

    function automatic logic model_ready(input logic [arch_w-1:0] r);
        if (!is_real(r)) return 1'b1;
        return rat_done[r] | pdone[rat[r]];
    endfunction

    // slot layout per opcode view
    task automatic decode_model(input microop_t u, output logic [3:0][arch_w-1:0] srcs,
                                output logic [3:0] imm, output logic [1:0] need);
        imm  = u.mem.imm;
        need = 2'b00;
        case (u.mem.opcode)
            op_bit: begin
                imm  = u.mem.f0;
                srcs = {4'h0, u.mem.f2, u.mem.f1, 4'h0};
                need = {1'b0, is_real(u.alu.dst0)};
            end
            op_load: begin
                srcs = {4'h0, u.mem.f2, u.mem.f1, u.mem.f0};
                need = {1'b0, is_real(u.alu.dst0)};
            end
            op_store: srcs = {u.mem.f3, u.mem.f2, u.mem.f1, u.mem.f0};
            op_cterm: begin
                imm  = u.mem.f0;
                srcs = {u.mem.f3, u.mem.f2, u.mem.f1, u.mem.imm};
            end
            op_term: begin
                imm  = u.mem.f0;
                srcs = {u.mem.f3, 8'h00, u.mem.imm};
            end
            default: begin
                imm  = 4'h0;
                srcs = {4'h0, u.alu.src2, u.alu.src1, u.alu.src0};
                need = {is_real(u.alu.dst1), is_real(u.alu.dst0)};
            end
        endcase
    endtask

    task automatic rename_dst(input logic [arch_w-1:0] d);
        logic [pr_addr_w-1:0] t;
        t = free_q.pop_front();
        retired.push_back(rat[d]);   // old mapping, dst0's tag too on a double write
        rat[d]      = t;
        rat_done[d] = 1'b0;
        pdone[t]    = 1'b0;
        inflight.push_back(t);
        allocs++;
    endtask

    task automatic update_model();
        if (wb_valid) pdone[wb_tag] = 1'b1;
        if (pend_acc && pend_need[0]) rename_dst(pend_d0);
        if (pend_acc && pend_need[1]) rename_dst(pend_d1);
        if (free_valid) free_q.push_back(free_tag);
        pend_acc = 1'b0;
    endtask

    task automatic drive_inputs(input int cyc);
        int k;
        int free_chance;
        in_valid   = ($random(seed) & 3) != 0;
        microop    = 24'($random(seed));
        wb_valid   = 1'b0;
        free_valid = 1'b0;
        if (inflight.size() > 0 && ($random(seed) & 1)) begin
            k        = $unsigned($random(seed)) % inflight.size();
            wb_tag   = inflight[k];
            wb_valid = 1'b1;
            inflight.delete(k);
        end
        free_chance = ((cyc / 500) % 2 == 0) ? 1 : 6;   // out of 8, starve then refill
        if (($unsigned($random(seed)) % 8) < free_chance) begin
            for (k = 0; k < retired.size(); k++) begin
                if (pdone[retired[k]]) break;
            end
            if (k < retired.size()) begin
                free_tag   = retired[k];
                free_valid = 1'b1;
                retired.delete(k);
            end
        end
    endtask

    task automatic check_outputs();
        check_value(3, "out_valid", exp_valid, out_valid);
        check_value(3, "dst_valid", exp_dvalid, dst_valid);
        if (exp_valid) begin
            for (int s = 0; s < 4; s++) begin
                check_value(1, $sformatf("src_regs[%0d]", s), exp_src[s], src_regs[s]);
                check_value(2, $sformatf("src_ready[%0d]", s), exp_rdy[s], src_ready[s]);
            end
            check_value(1, "immediate", exp_imm, immediate);
            for (int d = 0; d < 2; d++) begin
                if (exp_dvalid[d]) begin
                    check_value(3, $sformatf("dst_tags[%0d]", d), exp_tags[d], dst_tags[d]);
                end
            end
        end
    endtask

    initial begin
        logic [3:0][arch_w-1:0] srcs;
        logic [3:0]             imm;
        logic [1:0]             need;
        logic                   acc;
        logic                   exp_ready;
        logic                   was_stalled;
        int                     low_cycles;
        int                     stalls;
        int                     resumes;
        int                     same_dst;
        int                     total;
        int                     prop_fails;
        rst        = 1'b1;
        in_valid   = 1'b0;
        microop    = '0;
        wb_valid   = 1'b0;
        wb_tag     = '0;
        free_valid = 1'b0;
        free_tag   = '0;
        exp_valid  = 1'b0;
        exp_dvalid = 2'b00;
        pend_acc   = 1'b0;
        allocs     = 0;
        stalls     = 0;
        resumes    = 0;
        same_dst   = 0;
        was_stalled = 1'b0;
        for (int r = 0; r < 16; r++) begin
            rat[r]      = pr_addr_w'(r);
            rat_done[r] = 1'b1;
        end
        for (int p = 0; p < num_pr; p++) pdone[p] = 1'b1;
        for (int t = first_free; t < num_pr; t++) free_q.push_back(pr_addr_w'(t));

        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        low_cycles = 0;
        @(negedge clk);
        while (!in_ready && low_cycles < 40) begin
            low_cycles++;
            @(negedge clk);
        end
        check_value(0, "in_ready low cycles", 20, low_cycles);
        $display("test %s finished: %0d checks, %0d errors", test_name[0], checks[0], errs[0]);

        for (int cyc = 0; cyc < num_cycles; cyc++) begin
            @(posedge clk);
            update_model();
            #1;
            drive_inputs(cyc);
            @(negedge clk);
            check_outputs();
            decode_model(microop, srcs, imm, need);
            exp_ready = free_q.size() >= int'(need[0]) + int'(need[1]);
            check_value(4, "in_ready", exp_ready, in_ready);
            acc = in_valid && exp_ready;
            if (in_valid && !exp_ready) begin
                stalls++;
                was_stalled = 1'b1;
            end else if (was_stalled && exp_ready) begin
                resumes++;
                was_stalled = 1'b0;
            end
            exp_valid  = acc;
            exp_dvalid = acc ? need : 2'b00;
            if (acc) begin
                for (int s = 0; s < 4; s++) begin
                    exp_src[s] = model_tag(srcs[s]);
                    exp_rdy[s] = model_ready(srcs[s]);
                end
                exp_imm = imm;
                if (need[0]) exp_tags[0] = free_q[0];
                if (need[1]) exp_tags[1] = need[0] ? free_q[1] : free_q[0];
                if (need == 2'b11 && microop.alu.dst0 == microop.alu.dst1) same_dst++;
            end
            pend_acc  = acc;
            pend_need = need;
            pend_d0   = microop.alu.dst0;
            pend_d1   = microop.alu.dst1;
        end
        @(posedge clk);
        update_model();
        #1;
        in_valid   = 1'b0;
        wb_valid   = 1'b0;
        free_valid = 1'b0;
        @(negedge clk);
        check_outputs();

        assert (same_dst > 0) else begin
            $display("allocation: no microop wrote the same register twice");
            errs[3]++;
        end
        assert (stalls > 0 && resumes > 0) else begin
            $display("backpressure: in_ready never dropped and came back during the run");
            errs[4]++;
        end
        assert (allocs > num_pr - first_free) else begin
            $display("backpressure: no recycled tag was ever allocated");
            errs[4]++;
        end
        for (int t = 1; t < 5; t++) begin
            $display("test %s finished: %0d checks, %0d errors", test_name[t], checks[t], errs[t]);
        end
        prop_fails = uut.u_props.fails;
        total      = prop_fails;
        for (int t = 0; t < 5; t++) total += errs[t];
        $display("checks %0d, errors %0d, property failures %0d, stalls %0d, allocations %0d",
                 checks.sum(), total - prop_fails, prop_fails, stalls, allocs);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rename_pkg.sv
dest_if.sv
rename_lookup.sv
rename_decoder.sv
alias_table.sv
free_list.sv
ready_board.sv
init_counter.sv
rename_ctrl.sv
rename_unit.sv
rename_props.sv
tb_rename_unit.sv

// ==== Bender.yml ====
package:
  name: rename_unit

sources:
  - rename_pkg.sv
  - dest_if.sv
  - rename_lookup.sv
  - rename_decoder.sv
  - alias_table.sv
  - free_list.sv
  - ready_board.sv
  - init_counter.sv
  - rename_ctrl.sv
  - rename_unit.sv
  - target: simulation
    files:
      - rename_props.sv
      - tb_rename_unit.sv
